// File: hw/arch_map_table.sv
////////////////////////////////////////
// Committed rename map
// Written by the retiring instruction
// Exposes its post-write value
////////////////////////////////////////

`include "rename_config.svh"

module arch_map_table
    import rename_pkg::*;
(
    input  logic                           clock,
    input  logic                           arst_n,
    // Retire write
    input  logic                           write_en,
    input  arch_idx_t                      write_rd,
    input  phys_tag_t                      write_tag,
    // Map as it will be after this edge
    output phys_tag_t [`ARCH_REGS-1:0]     next_map
);

    phys_tag_t [`ARCH_REGS-1:0] map_q;

    // Bypass the retire write so a flush sees it
    always_comb begin
        next_map = map_q;
        if (write_en) begin
            next_map[write_rd] = write_tag;
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            // Same identity map as the speculative table
            for (int i = 0; i < `ARCH_REGS; i++) begin
                map_q[i] <= phys_tag_t'(i);
            end
        end else begin
            map_q <= next_map;
        end
    end

endmodule

// File: hw/free_list.sv
////////////////////////////////////////
// Physical tag free list
// Bitmap with lowest-index allocation
// Old tags returned at retire
// Rebuilt from committed map on flush
////////////////////////////////////////

`include "rename_config.svh"

module free_list
    import rename_pkg::*;
(
    input  logic                           clock,
    input  logic                           arst_n,
    // Allocation at dispatch
    input  logic                           alloc,
    output phys_tag_t                      alloc_tag,
    output logic                           empty,
    // Release at retire
    input  logic                           free_valid,
    input  phys_tag_t                      free_tag,
    // Recovery
    input  logic                           flush,
    input  phys_tag_t [`ARCH_REGS-1:0]     arch_next_map
);

    // One bit per physical register, set means free
    logic [`PHYS_REGS-1:0] free_q;
    logic [`PHYS_REGS-1:0] free_next;

    assign empty = ~|free_q;

    // Priority encoder, lowest set bit wins
    always_comb begin
        alloc_tag = '0;
        for (int i = `PHYS_REGS - 1; i >= 0; i--) begin
            if (free_q[i]) begin
                alloc_tag = phys_tag_t'(i);
            end
        end
    end

    ////////////////////////////////////////
    // Next bitmap
    ////////////////////////////////////////

    always_comb begin
        free_next = free_q;
        if (flush) begin
            // Everything not held by the committed map is free
            free_next = '1;
            for (int i = 0; i < `ARCH_REGS; i++) begin
                free_next[arch_next_map[i]] = 1'b0;
            end
        end else begin
            if (alloc) begin
                free_next[alloc_tag] = 1'b0;
            end
            // Old tag of a retiring instruction, never the one being allocated
            if (free_valid) begin
                free_next[free_tag] = 1'b1;
            end
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            // Tags below ARCH_REGS hold the identity map
            for (int i = 0; i < `PHYS_REGS; i++) begin
                free_q[i] <= (i >= `ARCH_REGS);
            end
        end else begin
            free_q <= free_next;
        end
    end

    // ROB gates dispatch on the empty flag
    a_no_alloc_when_empty: assert property (
        @(posedge clock) disable iff (!arst_n)
        alloc |-> !empty
    );

endmodule

// File: hw/map_table.sv
////////////////////////////////////////
// Speculative rename map
// One physical tag per arch register
// Combinational read of current mapping
// Bulk restore from the committed map
////////////////////////////////////////

`include "rename_config.svh"

module map_table
    import rename_pkg::*;
(
    input  logic                           clock,
    input  logic                           arst_n,
    // Rename write at dispatch
    input  logic                           write_en,
    input  arch_idx_t                      write_rd,
    input  phys_tag_t                      write_tag,
    // Old mapping lookup
    input  arch_idx_t                      read_rd,
    output phys_tag_t                      read_tag,
    // Recovery from the architected map
    input  logic                           restore,
    input  phys_tag_t [`ARCH_REGS-1:0]     restore_map
);

    // Current speculative mapping
    phys_tag_t map_q [`ARCH_REGS];

    // Lookup sees the map before this cycle's write
    assign read_tag = map_q[read_rd];

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            // Identity map out of reset
            for (int i = 0; i < `ARCH_REGS; i++) begin
                map_q[i] <= phys_tag_t'(i);
            end
        end else if (restore) begin
            // Whole table replaced, includes the retiring write
            for (int i = 0; i < `ARCH_REGS; i++) begin
                map_q[i] <= restore_map[i];
            end
        end else if (write_en) begin
            map_q[write_rd] <= write_tag;
        end
    end

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    // Dispatch is stalled by the ROB during a flush retire
    a_no_write_on_restore: assert property (
        @(posedge clock) disable iff (!arst_n)
        !(write_en && restore)
    );

endmodule

// File: hw/rename_config.svh
////////////////////////////////////////
// Rename core sizing
// ROB, architectural and physical sizes
// Index widths derived from the sizes
////////////////////////////////////////

`ifndef RENAME_CONFIG_SVH
`define RENAME_CONFIG_SVH

// Number of reorder buffer slots
`define ROB_DEPTH 8

// Architectural register count
`define ARCH_REGS 8

// Physical register count, must exceed ARCH_REGS
`define PHYS_REGS 16

// Index widths
`define ROB_IDX_W $clog2(`ROB_DEPTH)
`define ARCH_IDX_W $clog2(`ARCH_REGS)
`define PHYS_TAG_W $clog2(`PHYS_REGS)

`endif

// File: hw/rename_core.sv
////////////////////////////////////////
// Rename and commit core top level
// ROB, free list, speculative map
// and architected map
////////////////////////////////////////

`include "rename_config.svh"

module rename_core
    import rename_pkg::*;
(
    input  logic      clock,
    input  logic      arst_n,
    // Dispatch
    input  logic      dispatch_valid,
    input  arch_idx_t dispatch_rd,
    // Completion
    input  logic      complete_valid,
    input  rob_idx_t  complete_idx,
    input  logic      complete_mispred,
    // Back-pressure
    output logic      stall,
    // Dispatch results, same cycle
    output rob_idx_t  dispatch_idx,
    output phys_tag_t dispatch_tag,
    output phys_tag_t dispatch_old_tag,
    // Retire results
    output logic      retire_valid,
    output arch_idx_t retire_rd,
    output phys_tag_t retire_tag,
    output phys_tag_t retire_old_tag,
    output logic      retire_flush
);

    ////////////////////////////////////////
    // Internal wires
    ////////////////////////////////////////

    logic                       dispatch_fire;
    logic                       list_empty;
    phys_tag_t [`ARCH_REGS-1:0] arch_next_map;

    rob rob_0 (
        .clock            (clock),
        .arst_n           (arst_n),
        .dispatch_valid   (dispatch_valid),
        .dispatch_rd      (dispatch_rd),
        .new_tag          (dispatch_tag),
        .old_tag          (dispatch_old_tag),
        .list_empty       (list_empty),
        .complete_valid   (complete_valid),
        .complete_idx     (complete_idx),
        .complete_mispred (complete_mispred),
        .stall            (stall),
        .dispatch_fire    (dispatch_fire),
        .dispatch_idx     (dispatch_idx),
        .retire_valid     (retire_valid),
        .retire_rd        (retire_rd),
        .retire_tag       (retire_tag),
        .retire_old_tag   (retire_old_tag),
        .retire_flush     (retire_flush)
    );

    // Lowest free tag feeds dispatch directly
    free_list free_list_0 (
        .clock         (clock),
        .arst_n        (arst_n),
        .alloc         (dispatch_fire),
        .alloc_tag     (dispatch_tag),
        .empty         (list_empty),
        .free_valid    (retire_valid),
        .free_tag      (retire_old_tag),
        .flush         (retire_flush),
        .arch_next_map (arch_next_map)
    );

    map_table map_table_0 (
        .clock       (clock),
        .arst_n      (arst_n),
        .write_en    (dispatch_fire),
        .write_rd    (dispatch_rd),
        .write_tag   (dispatch_tag),
        .read_rd     (dispatch_rd),
        .read_tag    (dispatch_old_tag),
        .restore     (retire_flush),
        .restore_map (arch_next_map)
    );

    // Committed map updated by every retire
    arch_map_table arch_map_table_0 (
        .clock     (clock),
        .arst_n    (arst_n),
        .write_en  (retire_valid),
        .write_rd  (retire_rd),
        .write_tag (retire_tag),
        .next_map  (arch_next_map)
    );

endmodule

// File: hw/rename_pkg.sv
////////////////////////////////////////
// Rename core shared types
// Register index and physical tag types
// ROB slot index
// ROB entry state encoding
////////////////////////////////////////

`include "rename_config.svh"

package rename_pkg;

    // Architectural destination register
    typedef logic [`ARCH_IDX_W-1:0] arch_idx_t;

    // Physical register tag
    typedef logic [`PHYS_TAG_W-1:0] phys_tag_t;

    // ROB slot index, wraps naturally at ROB_DEPTH
    typedef logic [`ROB_IDX_W-1:0] rob_idx_t;

    ////////////////////////////////////////
    // ROB entry lifecycle
    ////////////////////////////////////////

    // FREE -> BUSY on dispatch
    // BUSY -> DONE or MISPRED on completion
    // DONE / MISPRED -> FREE on retire
    typedef enum logic [1:0] {
        ROB_FREE    = 2'd0,
        ROB_BUSY    = 2'd1,
        ROB_DONE    = 2'd2,
        ROB_MISPRED = 2'd3
    } rob_state_e;

endpackage

// File: hw/rob.sv
////////////////////////////////////////
// Reorder buffer
// Dispatch gating and slot allocation
// Out-of-order completion marking
// In-order retire and mispredict flush
////////////////////////////////////////

`include "rename_config.svh"

module rob
    import rename_pkg::*;
(
    input  logic      clock,
    input  logic      arst_n,
    // Dispatch request and rename results
    input  logic      dispatch_valid,
    input  arch_idx_t dispatch_rd,
    input  phys_tag_t new_tag,
    input  phys_tag_t old_tag,
    input  logic      list_empty,
    // Completion strobe
    input  logic      complete_valid,
    input  rob_idx_t  complete_idx,
    input  logic      complete_mispred,
    // Dispatch gating
    output logic      stall,
    output logic      dispatch_fire,
    output rob_idx_t  dispatch_idx,
    // Head retire
    output logic      retire_valid,
    output arch_idx_t retire_rd,
    output phys_tag_t retire_tag,
    output phys_tag_t retire_old_tag,
    output logic      retire_flush
);

    // Occupancy counter has to hold ROB_DEPTH itself
    localparam int unsigned CNT_W = $clog2(`ROB_DEPTH + 1);
    localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(`ROB_DEPTH);

    // Per-slot state and payload
    rob_state_e       state_q   [`ROB_DEPTH];
    arch_idx_t        rd_q      [`ROB_DEPTH];
    phys_tag_t        tag_q     [`ROB_DEPTH];
    phys_tag_t        old_tag_q [`ROB_DEPTH];
    rob_idx_t         head_q;
    rob_idx_t         tail_q;
    logic [CNT_W-1:0] count_q;
    logic             full;
    rob_state_e       head_state;

    ////////////////////////////////////////
    // Dispatch gating
    ////////////////////////////////////////

    assign full          = (count_q == FULL_CNT);
    assign stall         = full || list_empty || retire_flush;
    assign dispatch_fire = dispatch_valid && !stall;
    assign dispatch_idx  = tail_q;

    ////////////////////////////////////////
    // Head retire
    ////////////////////////////////////////

    assign head_state     = state_q[head_q];
    assign retire_valid   = (head_state == ROB_DONE) || (head_state == ROB_MISPRED);
    // A mispredicted head is always retire-ready
    assign retire_flush   = (head_state == ROB_MISPRED);
    assign retire_rd      = rd_q[head_q];
    assign retire_tag     = tag_q[head_q];
    assign retire_old_tag = old_tag_q[head_q];

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `ROB_DEPTH; i++) begin
                state_q[i] <= ROB_FREE;
            end
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else if (retire_flush) begin
            // Drop everything younger, restart at slot 0
            for (int i = 0; i < `ROB_DEPTH; i++) begin
                state_q[i] <= ROB_FREE;
            end
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (retire_valid) begin
                state_q[head_q] <= ROB_FREE;
                head_q          <= head_q + 1'b1;
            end
            if (dispatch_fire) begin
                state_q[tail_q] <= ROB_BUSY;
                tail_q          <= tail_q + 1'b1;
            end
            // Completion can land on any outstanding slot
            if (complete_valid) begin
                state_q[complete_idx] <= complete_mispred ? ROB_MISPRED : ROB_DONE;
            end
            case ({dispatch_fire, retire_valid})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // Payload captured at dispatch only
    always_ff @(posedge clock) begin
        if (dispatch_fire) begin
            rd_q[tail_q]      <= dispatch_rd;
            tag_q[tail_q]     <= new_tag;
            old_tag_q[tail_q] <= old_tag;
        end
    end

    // Completion source must only name dispatched, unretired slots
    a_complete_live_slot: assert property (
        @(posedge clock) disable iff (!arst_n)
        complete_valid |-> (state_q[complete_idx] != ROB_FREE)
    );

endmodule

// File: project.f
+incdir+hw
hw/rename_pkg.sv
hw/map_table.sv
hw/arch_map_table.sv
hw/free_list.sv
hw/rob.sv
hw/rename_core.sv
verif/tb_clock_gen.sv
verif/rename_core_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the rename core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module rename_core_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vrename_core_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Simulation passed"; then
    exit 0
else
    echo "Pass line not found in simulator output"
    exit 1
fi

// File: verif/rename_core_tb.sv
////////////////////////////////////////
// Rename core testbench
// Xorshift dispatch and completion stimulus
// Model of maps, free bitmap and ROB
// Typed compare tasks and cycle watchdog
////////////////////////////////////////

`include "rename_config.svh"

module rename_core_tb
    import rename_pkg::*;
();

    localparam int STIM_CYCLES    = 1500;
    // Reset, stimulus and drain all fit well inside the margin
    localparam int TIMEOUT_CYCLES = STIM_CYCLES + 500;

    logic      clock;
    logic      arst_n;
    logic      dispatch_valid;
    arch_idx_t dispatch_rd;
    logic      complete_valid;
    rob_idx_t  complete_idx;
    logic      complete_mispred;
    logic      stall;
    rob_idx_t  dispatch_idx;
    phys_tag_t dispatch_tag;
    phys_tag_t dispatch_old_tag;
    logic      retire_valid;
    arch_idx_t retire_rd;
    phys_tag_t retire_tag;
    phys_tag_t retire_old_tag;
    logic      retire_flush;

    // Model state, mirrors the registered state of the DUT
    phys_tag_t             spec_map [`ARCH_REGS];
    phys_tag_t             arch_map [`ARCH_REGS];
    logic [`PHYS_REGS-1:0] free_bits;
    rob_state_e            m_state  [`ROB_DEPTH];
    arch_idx_t             m_rd     [`ROB_DEPTH];
    phys_tag_t             m_tag    [`ROB_DEPTH];
    phys_tag_t             m_old    [`ROB_DEPTH];
    rob_idx_t              m_head;
    rob_idx_t              m_tail;
    int                    m_count;

    logic [31:0] rng_state       = 32'hf128_0232;
    int          cycle_count     = 0;
    int          fail_count      = 0;
    int          retire_count    = 0;
    int          flush_count     = 0;
    logic        first_fire_done = 1'b0;
    logic        after_flush     = 1'b0;
    logic        draining        = 1'b0;

    tb_clock_gen #(.RESET_CYCLES(16)) clock_gen_0 (
        .clock  (clock),
        .arst_n (arst_n)
    );

    rename_core dut (
        .clock            (clock),
        .arst_n           (arst_n),
        .dispatch_valid   (dispatch_valid),
        .dispatch_rd      (dispatch_rd),
        .complete_valid   (complete_valid),
        .complete_idx     (complete_idx),
        .complete_mispred (complete_mispred),
        .stall            (stall),
        .dispatch_idx     (dispatch_idx),
        .dispatch_tag     (dispatch_tag),
        .dispatch_old_tag (dispatch_old_tag),
        .retire_valid     (retire_valid),
        .retire_rd        (retire_rd),
        .retire_tag       (retire_tag),
        .retire_old_tag   (retire_old_tag),
        .retire_flush     (retire_flush)
    );

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Lowest set bit of the free bitmap
    function automatic phys_tag_t lowest_free(input logic [`PHYS_REGS-1:0] bits);
        for (int i = 0; i < `PHYS_REGS; i++) begin
            if (bits[i]) begin
                return phys_tag_t'(i);
            end
        end
        return '0;
    endfunction

    task automatic check_tag(input string name, input phys_tag_t exp, input phys_tag_t act);
        if (act !== exp) begin
            $display("[ERROR] %s expected 0x%0h actual 0x%0h at cycle %0d",
                     name, exp, act, cycle_count);
            fail_count++;
            $display("Simulation failed");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic check_rob_idx(input string name, input rob_idx_t exp, input rob_idx_t act);
        if (act !== exp) begin
            $display("[ERROR] %s expected 0x%0h actual 0x%0h at cycle %0d",
                     name, exp, act, cycle_count);
            fail_count++;
            $display("Simulation failed");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic check_arch_idx(input string name, input arch_idx_t exp, input arch_idx_t act);
        if (act !== exp) begin
            $display("[ERROR] %s expected 0x%0h actual 0x%0h at cycle %0d",
                     name, exp, act, cycle_count);
            fail_count++;
            $display("Simulation failed");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[ERROR] %s expected 0x%0h actual 0x%0h at cycle %0d",
                     name, exp, act, cycle_count);
            fail_count++;
            $display("Simulation failed");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    task automatic clear_rob();
        for (int i = 0; i < `ROB_DEPTH; i++) begin
            m_state[i] = ROB_FREE;
        end
        m_head  = '0;
        m_tail  = '0;
        m_count = 0;
    endtask

    // Identity map, tags above the map free
    task automatic reset_model();
        for (int i = 0; i < `ARCH_REGS; i++) begin
            spec_map[i] = phys_tag_t'(i);
            arch_map[i] = phys_tag_t'(i);
        end
        for (int i = 0; i < `PHYS_REGS; i++) begin
            free_bits[i] = (i >= `ARCH_REGS);
        end
        clear_rob();
    endtask

    // Rising edge: new random request, completions only on BUSY slots
    task automatic drive_inputs();
        rob_idx_t busy [$];
        rng_state = xorshift32(rng_state);
        for (int i = 0; i < `ROB_DEPTH; i++) begin
            if (m_state[i] == ROB_BUSY) begin
                busy.push_back(rob_idx_t'(i));
            end
        end
        dispatch_valid   <= !draining && (rng_state[1:0] != 2'b00);
        dispatch_rd      <= arch_idx_t'(rng_state >> 4);
        complete_valid   <= (busy.size() != 0) && (rng_state[9:8] != 2'b00);
        // About one completion in 16 is a mispredict
        complete_mispred <= (rng_state[15:12] == 4'h0);
        if (busy.size() != 0) begin
            complete_idx <= busy[(rng_state >> 16) % busy.size()];
        end else begin
            complete_idx <= rob_idx_t'(rng_state >> 16);
        end
    endtask

    // Falling edge: compare outputs, then advance the model one edge
    task automatic check_and_step();
        rob_state_e head_state;
        logic       exp_retire;
        logic       exp_flush;
        logic       exp_stall;
        logic       fire;
        phys_tag_t  new_tag;
        head_state = m_state[m_head];
        exp_retire = (head_state == ROB_DONE) || (head_state == ROB_MISPRED);
        exp_flush  = (head_state == ROB_MISPRED);
        exp_stall  = (m_count == `ROB_DEPTH) || (free_bits == '0) || exp_flush;
        fire       = dispatch_valid && !exp_stall;
        new_tag    = lowest_free(free_bits);

        check_bit("stall", exp_stall, stall);
        check_bit("retire_valid", exp_retire, retire_valid);
        check_bit("retire_flush", exp_flush, retire_flush);
        if (exp_retire) begin
            check_arch_idx("retire_rd", m_rd[m_head], retire_rd);
            check_tag("retire_tag", m_tag[m_head], retire_tag);
            check_tag("retire_old_tag", m_old[m_head], retire_old_tag);
        end
        if (fire) begin
            if (!first_fire_done) begin
                // First rename gets the first tag above the identity map
                check_tag("dispatch_tag", phys_tag_t'(`ARCH_REGS), dispatch_tag);
                check_tag("dispatch_old_tag", phys_tag_t'(dispatch_rd), dispatch_old_tag);
                first_fire_done = 1'b1;
            end
            if (after_flush) begin
                check_tag("dispatch_old_tag", arch_map[dispatch_rd], dispatch_old_tag);
                after_flush = 1'b0;
            end
            check_rob_idx("dispatch_idx", m_tail, dispatch_idx);
            check_tag("dispatch_tag", new_tag, dispatch_tag);
            check_tag("dispatch_old_tag", spec_map[dispatch_rd], dispatch_old_tag);
        end

        // Retire writes the committed map, flush or not
        if (exp_retire) begin
            arch_map[m_rd[m_head]] = m_tag[m_head];
            retire_count++;
        end
        if (exp_flush) begin
            // ROB empties, map restored, free set rebuilt
            flush_count++;
            after_flush = 1'b1;
            clear_rob();
            free_bits = '1;
            for (int i = 0; i < `ARCH_REGS; i++) begin
                spec_map[i] = arch_map[i];
                free_bits[arch_map[i]] = 1'b0;
            end
        end else begin
            if (exp_retire) begin
                free_bits[m_old[m_head]] = 1'b1;
                m_state[m_head] = ROB_FREE;
                m_head = m_head + 1'b1;
                m_count--;
            end
            if (fire) begin
                m_state[m_tail] = ROB_BUSY;
                m_rd[m_tail] = dispatch_rd;
                m_tag[m_tail] = new_tag;
                m_old[m_tail] = spec_map[dispatch_rd];
                free_bits[new_tag] = 1'b0;
                spec_map[dispatch_rd] = new_tag;
                m_tail = m_tail + 1'b1;
                m_count++;
            end
            if (complete_valid) begin
                m_state[complete_idx] = complete_mispred ? ROB_MISPRED : ROB_DONE;
            end
        end
    endtask

    ////////////////////////////////////////
    // Run control
    ////////////////////////////////////////

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation failed");
            $fatal(1, "Watchdog expired");
        end
    end

    initial begin
        dispatch_valid   = 1'b0;
        dispatch_rd      = '0;
        complete_valid   = 1'b0;
        complete_idx     = '0;
        complete_mispred = 1'b0;
        reset_model();
        @(posedge arst_n);
        @(negedge clock);
        // Idle right after reset
        check_bit("stall", 1'b0, stall);
        check_bit("retire_valid", 1'b0, retire_valid);
        check_bit("retire_flush", 1'b0, retire_flush);
        for (int c = 0; c < STIM_CYCLES; c++) begin
            @(posedge clock);
            drive_inputs();
            @(negedge clock);
            check_and_step();
        end
        // Drain with dispatch off until the model ROB is empty
        draining = 1'b1;
        while (m_count != 0) begin
            @(posedge clock);
            drive_inputs();
            @(negedge clock);
            check_and_step();
        end
        if (retire_count == 0 || flush_count == 0) begin
            $display("The run saw no retire or no mispredict flush");
            fail_count++;
        end
        if (fail_count == 0) begin
            $display("Simulation passed");
            $finish;
        end else begin
            $display("Simulation failed");
            $fatal(1, "Run incomplete");
        end
    end

endmodule

// File: verif/tb_clock_gen.sv
////////////////////////////////////////
// Testbench clock and reset
// Period 10, reset held low at start
////////////////////////////////////////

module tb_clock_gen #(
    parameter int RESET_CYCLES = 16
) (
    output logic clock,
    output logic arst_n
);

    // Free-running clock, 10 time units per cycle
    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // Release on a rising edge after RESET_CYCLES cycles
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        arst_n <= 1'b1;
    end

endmodule
